//--- project.f
+incdir+common
common/memSysPkg.sv
icache/instrCache.sv
dcache/dataCache.sv
design/busArbiter.sv
design/mainMemory.sv
design/memSystem.sv
bench/clockGen.sv
bench/memSystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module memSystemTb -f project.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

//--- bench/memSystemTb.sv
`timescale 1ns/1ps
`include "memSys_consts.svh"

module memSystemTb
  import memSysPkg::*;
();

  localparam int TIMEOUT   = 200;
  localparam int RAND_OPS  = 300;
  localparam int WORD_BITS = $clog2(`MEM_WORDS);

  logic        clk;
  logic        rst;
  logic        fetchReq;
  logic [31:0] fetchAddr;
  logic        fetchAck;
  logic [31:0] fetchData;
  logic        dataReq;
  busOp        dataOp;
  logic [31:0] dataAddr;
  logic [31:0] dataWData;
  logic        dataAck;
  logic [31:0] dataRData;

  int errorCount;
  int checkCount;

  // Reference memory that follows every store
  logic [31:0] refMem [`MEM_WORDS];

  // Which line each cache should hold per index
  logic [`TAG_BITS-1:0] iTagModel [`NUM_LINES];
  logic [`TAG_BITS-1:0] dTagModel [`NUM_LINES];
  bit   [`NUM_LINES-1:0] iValidModel;
  bit   [`NUM_LINES-1:0] dValidModel;

  clockGen clocks (.clk(clk), .rst(rst));

  memSystem DUT (
    .clk(clk), .rst(rst),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .fetchAck(fetchAck), .fetchData(fetchData),
    .dataReq(dataReq), .dataOp(dataOp), .dataAddr(dataAddr),
    .dataWData(dataWData), .dataAck(dataAck), .dataRData(dataRData)
  );

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [`INDEX_BITS-1:0] lineIndex(input logic [31:0] addr);
    return addr[2 + `OFFSET_BITS +: `INDEX_BITS];
  endfunction

  function automatic logic [`TAG_BITS-1:0] lineTag(input logic [31:0] addr);
    return addr[31 -: `TAG_BITS];
  endfunction

  // Three tags over four indexes so that lines evict each other
  function automatic logic [31:0] randomAddr(input bit upperHalf);
    logic [31:0] addr;
    addr       = '0;
    addr[11]   = upperHalf;
    addr[9:8]  = 2'($urandom % 3);
    addr[5:4]  = 2'($urandom % 4);
    addr[3:2]  = 2'($urandom % 4);
    return addr;
  endfunction

  // Counts rising edges until ack while looking on falling edges
  task automatic waitAckHigh(input bit dataSide, output int edges, output bit ok);
    edges = 0;
    ok    = 1'b0;
    while (!ok && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      ok = dataSide ? dataAck : fetchAck;
    end
    if (!ok) begin
      errorCount++;
      $display("timeout: %s ack did not rise", dataSide ? "data" : "fetch");
    end
  endtask

  task automatic waitAckLow(input bit dataSide);
    int cycles = 0;
    bit low = 1'b0;
    while (!low && cycles < TIMEOUT) begin
      @(posedge clk);
      @(negedge clk);
      cycles++;
      low = dataSide ? !dataAck : !fetchAck;
    end
    if (!low) begin
      errorCount++;
      $display("timeout: %s ack did not fall", dataSide ? "data" : "fetch");
    end
  endtask

  // One four-phase fetch entered and left on a falling edge
  task automatic fetchWord(input logic [31:0] addr, input string name);
    int edges;
    bit ok;
    bit expectHit;
    logic [`INDEX_BITS-1:0] idx;
    idx       = lineIndex(addr);
    expectHit = iValidModel[idx] && (iTagModel[idx] == lineTag(addr));
    fetchAddr = addr;
    fetchReq  = 1'b1;
    waitAckHigh(1'b0, edges, ok);
    if (ok) begin
      checkValue(name, refMem[addr[2 +: WORD_BITS]], fetchData);
      // Lookup edge plus respond edge
      if (expectHit) begin
        checkValue({name, " hit latency"}, 32'd2, edges);
      end
      iValidModel[idx] = 1'b1;
      iTagModel[idx]   = lineTag(addr);
    end
    fetchReq = 1'b0;
    waitAckLow(1'b0);
  endtask

  task automatic accessData(input busOp op, input logic [31:0] addr,
                            input logic [31:0] wdata, input string name);
    int edges;
    bit ok;
    bit expectHit;
    logic [`INDEX_BITS-1:0] idx;
    idx       = lineIndex(addr);
    expectHit = dValidModel[idx] && (dTagModel[idx] == lineTag(addr));
    dataOp    = op;
    dataAddr  = addr;
    dataWData = wdata;
    dataReq   = 1'b1;
    waitAckHigh(1'b1, edges, ok);
    if (ok && op == BUS_WRITE) begin
      // Write-through without allocate
      refMem[addr[2 +: WORD_BITS]] = wdata;
    end else if (ok) begin
      checkValue(name, refMem[addr[2 +: WORD_BITS]], dataRData);
      if (expectHit) begin
        checkValue({name, " hit latency"}, 32'd2, edges);
      end
      dValidModel[idx] = 1'b1;
      dTagModel[idx]   = lineTag(addr);
    end
    dataReq = 1'b0;
    waitAckLow(1'b1);
  endtask

  task automatic randomFetches();
    repeat (RAND_OPS) begin
      fetchWord(randomAddr(1'b0), "random fetch");
      repeat ($urandom % 3) @(negedge clk);
    end
  endtask

  // Data side stays in the upper half away from code
  task automatic randomDataOps();
    repeat (RAND_OPS) begin
      if ($urandom % 2) begin
        accessData(BUS_WRITE, randomAddr(1'b1), $urandom, "random store");
      end else begin
        accessData(BUS_READ, randomAddr(1'b1), 32'h0, "random load");
      end
      repeat ($urandom % 3) @(negedge clk);
    end
  endtask

  initial begin
    int waitCycles;
    void'($urandom(32'ha270));
    errorCount  = 0;
    checkCount  = 0;
    fetchReq    = 1'b0;
    fetchAddr   = '0;
    dataReq     = 1'b0;
    dataOp      = BUS_READ;
    dataAddr    = '0;
    dataWData   = '0;
    iValidModel = '0;
    dValidModel = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      refMem[i] = 32'(i) ^ `INIT_PATTERN;
    end

    waitCycles = 0;
    while (rst !== 1'b0 && waitCycles < TIMEOUT) begin
      @(negedge clk);
      waitCycles++;
    end
    if (rst !== 1'b0) begin
      errorCount++;
      $display("timeout: reset was never released");
    end

    // No ack while no req
    repeat (5) begin
      @(negedge clk);
      checkValue("idle fetchAck", 32'd0, {31'b0, fetchAck});
      checkValue("idle dataAck", 32'd0, {31'b0, dataAck});
    end

    fetchWord(32'h0000_0100, "fetch miss");
    fetchWord(32'h0000_0108, "fetch same line");
    fetchWord(32'h0000_0100, "fetch repeat");

    accessData(BUS_READ, 32'h0000_0900, 32'h0, "load miss");
    accessData(BUS_READ, 32'h0000_090C, 32'h0, "load neighbour");

    // Line of 0x904 is cached but line of 0xA20 is not
    accessData(BUS_WRITE, 32'h0000_0904, 32'h1357_9BDF, "store hit");
    accessData(BUS_READ, 32'h0000_0904, 32'h0, "load after store hit");
    accessData(BUS_WRITE, 32'h0000_0A20, 32'h2468_ACE0, "store miss");
    accessData(BUS_READ, 32'h0000_0A20, 32'h0, "load after store miss");

    // Both ports compete for the bus
    fork
      randomFetches();
      randomDataOps();
    join

    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held for 8 rising edges and released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- design/memSystem.sv
`timescale 1ns/1ps

module memSystem
  import memSysPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        fetchReq,
  input  logic [31:0] fetchAddr,
  output logic        fetchAck,
  output logic [31:0] fetchData,
  input  logic        dataReq,
  input  busOp        dataOp,
  input  logic [31:0] dataAddr,
  input  logic [31:0] dataWData,
  output logic        dataAck,
  output logic [31:0] dataRData
);

  // Cache side of the arbiter
  logic        iBusReq, iBusAck, dBusReq, dBusAck;
  logic [31:0] iBusAddr, dBusAddr, dBusWData, busRData;
  busOp        dBusOp;

  // Memory side of the arbiter
  logic        memReq, memAck;
  busOp        memOp;
  logic [31:0] memAddr, memWData, memRData;

  instrCache icache (
    .clk(clk), .rst(rst),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .fetchAck(fetchAck), .fetchData(fetchData),
    .busReq(iBusReq), .busAddr(iBusAddr),
    .busAck(iBusAck), .busRData(busRData)
  );

  dataCache dcache (
    .clk(clk), .rst(rst),
    .dataReq(dataReq), .dataOp(dataOp), .dataAddr(dataAddr),
    .dataWData(dataWData), .dataAck(dataAck), .dataRData(dataRData),
    .busReq(dBusReq), .busOp(dBusOp), .busAddr(dBusAddr),
    .busWData(dBusWData), .busAck(dBusAck), .busRData(busRData)
  );

  busArbiter arbiter (
    .clk(clk), .rst(rst),
    .iBusReq(iBusReq), .iBusAddr(iBusAddr), .iBusAck(iBusAck),
    .dBusReq(dBusReq), .dBusOp(dBusOp), .dBusAddr(dBusAddr),
    .dBusWData(dBusWData), .dBusAck(dBusAck), .busRData(busRData),
    .memReq(memReq), .memOp(memOp), .memAddr(memAddr),
    .memWData(memWData), .memAck(memAck), .memRData(memRData)
  );

  mainMemory memory (
    .clk(clk), .rst(rst),
    .memReq(memReq), .memOp(memOp), .memAddr(memAddr),
    .memWData(memWData), .memAck(memAck), .memRData(memRData)
  );

endmodule

//--- design/mainMemory.sv
`timescale 1ns/1ps
`include "memSys_consts.svh"

module mainMemory
  import memSysPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        memReq,
  input  busOp        memOp,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWData,
  output logic        memAck,
  output logic [31:0] memRData
);

  localparam int ADDR_BITS = $clog2(`MEM_WORDS);

  logic [31:0]          memArr [`MEM_WORDS];
  logic [ADDR_BITS-1:0] wordIdx;
  logic [3:0]           latCnt;
  logic                 ackRise;

  // Word index above the byte offset
  assign wordIdx = memAddr[2 +: ADDR_BITS];

  // Last wait cycle of a pending request
  assign ackRise = memReq && !memAck && (latCnt == 4'(`MEM_LATENCY - 1));

  // Preload word i with i ^ pattern
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      memArr[i] = 32'(i) ^ `INIT_PATTERN;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      latCnt <= '0;
      memAck <= 1'b0;
    end else if (memAck) begin
      // Four-phase release
      if (!memReq) begin
        memAck <= 1'b0;
      end
    end else if (memReq) begin
      if (ackRise) begin
        memAck <= 1'b1;
        latCnt <= '0;
      end else begin
        latCnt <= latCnt + 4'd1;
      end
    end
  end

  // Access happens on the ack edge with read data valid alongside ack
  always @(posedge clk) begin
    if (ackRise) begin
      if (memOp == BUS_WRITE) begin
        memArr[wordIdx] <= memWData;
      end
      memRData <= memArr[wordIdx];
    end
  end

endmodule

//--- design/busArbiter.sv
`timescale 1ns/1ps

module busArbiter
  import memSysPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        iBusReq,
  input  logic [31:0] iBusAddr,
  output logic        iBusAck,
  input  logic        dBusReq,
  input  busOp        dBusOp,
  input  logic [31:0] dBusAddr,
  input  logic [31:0] dBusWData,
  output logic        dBusAck,
  output logic [31:0] busRData,
  output logic        memReq,
  output busOp        memOp,
  output logic [31:0] memAddr,
  output logic [31:0] memWData,
  input  logic        memAck,
  input  logic [31:0] memRData
);

  // Current bus owner
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_INSTR,
    GNT_DATA
  } grantState;

  grantState grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= GNT_NONE;
    end else begin
      unique case (grant)
        GNT_NONE: begin
          // Data side wins a tie
          if (dBusReq) begin
            grant <= GNT_DATA;
          end else if (iBusReq) begin
            grant <= GNT_INSTR;
          end
        end
        GNT_INSTR: begin
          // Release only after the full four-phase exchange
          if (!iBusReq && !memAck) begin
            grant <= GNT_NONE;
          end
        end
        GNT_DATA: begin
          if (!dBusReq && !memAck) begin
            grant <= GNT_NONE;
          end
        end
        default: grant <= GNT_NONE;
      endcase
    end
  end

  // Read word goes to both but only the owner sees ack
  assign busRData = memRData;

  always_comb begin
    memReq   = 1'b0;
    memOp    = BUS_READ;
    memAddr  = iBusAddr;
    memWData = '0;
    iBusAck  = 1'b0;
    dBusAck  = 1'b0;
    unique case (grant)
      GNT_INSTR: begin
        memReq  = iBusReq;
        iBusAck = memAck;
      end
      GNT_DATA: begin
        memReq   = dBusReq;
        memOp    = dBusOp;
        memAddr  = dBusAddr;
        memWData = dBusWData;
        dBusAck  = memAck;
      end
      default: ;
    endcase
  end

endmodule

//--- dcache/dataCache.sv
`timescale 1ns/1ps
`include "memSys_consts.svh"

module dataCache
  import memSysPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             dataReq,
  input  memSysPkg::busOp  dataOp,
  input  logic [31:0]      dataAddr,
  input  logic [31:0]      dataWData,
  output logic             dataAck,
  output logic [31:0]      dataRData,
  output logic             busReq,
  output memSysPkg::busOp  busOp,
  output logic [31:0]      busAddr,
  output logic [31:0]      busWData,
  input  logic             busAck,
  input  logic [31:0]      busRData
);

  cacheState state;

  // Line storage
  logic [`NUM_LINES-1:0] validArr;
  logic [`TAG_BITS-1:0]  tagArr  [`NUM_LINES];
  logic [31:0]           dataArr [`NUM_LINES][`LINE_WORDS];

  // Word being refilled within the line
  logic [`OFFSET_BITS-1:0] refillCnt;

  logic [`TAG_BITS-1:0]    reqTag;
  logic [`INDEX_BITS-1:0]  reqIndex;
  logic [`OFFSET_BITS-1:0] reqOffset;
  logic                    hit;
  logic                    lastWord;
  logic                    storing;

  // Fields of the data address
  assign reqTag    = dataAddr[31 -: `TAG_BITS];
  assign reqIndex  = dataAddr[2 + `OFFSET_BITS +: `INDEX_BITS];
  assign reqOffset = dataAddr[2 +: `OFFSET_BITS];

  assign hit      = validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign lastWord = &refillCnt;
  assign storing  = (state == STORE_REQ);

  // One bus port shared by refill reads and write-through stores
  assign busReq   = (state == REFILL_REQ) || storing;
  assign busOp    = storing ? BUS_WRITE : BUS_READ;
  assign busAddr  = storing ? {dataAddr[31:2], 2'b00}
                            : {reqTag, reqIndex, refillCnt, 2'b00};
  assign busWData = dataWData;
  assign dataAck  = (state == RESPOND);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      refillCnt <= '0;
      validArr  <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          if (dataReq) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          // Stores always go out on a hit or a miss
          if (dataOp == BUS_WRITE) begin
            state <= STORE_REQ;
          end else if (hit) begin
            state <= RESPOND;
          end else begin
            refillCnt <= '0;
            state     <= REFILL_REQ;
          end
        end
        REFILL_REQ: begin
          if (busAck) begin
            if (lastWord) begin
              validArr[reqIndex] <= 1'b1;
            end
            state <= REFILL_WAIT;
          end
        end
        REFILL_WAIT: begin
          if (!busAck) begin
            if (lastWord) begin
              state <= LOOKUP;
            end else begin
              refillCnt <= refillCnt + 1'b1;
              state     <= REFILL_REQ;
            end
          end
        end
        STORE_REQ: begin
          if (busAck) begin
            state <= STORE_WAIT;
          end
        end
        STORE_WAIT: begin
          // Ack the CPU only once the bus handshake is closed
          if (!busAck) begin
            state <= RESPOND;
          end
        end
        RESPOND: begin
          if (!dataReq) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == REFILL_REQ && busAck) begin
      dataArr[reqIndex][refillCnt] <= busRData;
      if (lastWord) begin
        tagArr[reqIndex] <= reqTag;
      end
    end
    // Store hit keeps the line in step with memory
    if (storing && busAck && hit) begin
      dataArr[reqIndex][reqOffset] <= dataWData;
    end
    if (state == LOOKUP && dataOp == BUS_READ && hit) begin
      dataRData <= dataArr[reqIndex][reqOffset];
    end
  end

endmodule

//--- icache/instrCache.sv
`timescale 1ns/1ps
`include "memSys_consts.svh"

module instrCache
  import memSysPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        fetchReq,
  input  logic [31:0] fetchAddr,
  output logic        fetchAck,
  output logic [31:0] fetchData,
  output logic        busReq,
  output logic [31:0] busAddr,
  input  logic        busAck,
  input  logic [31:0] busRData
);

  cacheState state;

  // Line storage
  logic [`NUM_LINES-1:0] validArr;
  logic [`TAG_BITS-1:0]  tagArr  [`NUM_LINES];
  logic [31:0]           dataArr [`NUM_LINES][`LINE_WORDS];

  // Word being refilled within the line
  logic [`OFFSET_BITS-1:0] refillCnt;

  logic [`TAG_BITS-1:0]    reqTag;
  logic [`INDEX_BITS-1:0]  reqIndex;
  logic [`OFFSET_BITS-1:0] reqOffset;
  logic                    hit;
  logic                    lastWord;

  // Fields of the fetch address
  assign reqTag    = fetchAddr[31 -: `TAG_BITS];
  assign reqIndex  = fetchAddr[2 + `OFFSET_BITS +: `INDEX_BITS];
  assign reqOffset = fetchAddr[2 +: `OFFSET_BITS];

  assign hit      = validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  // Counter saturated on the last word of the line
  assign lastWord = &refillCnt;

  // Refill reads walk the aligned line
  assign busReq   = (state == REFILL_REQ);
  assign busAddr  = {reqTag, reqIndex, refillCnt, 2'b00};
  assign fetchAck = (state == RESPOND);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      refillCnt <= '0;
      validArr  <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          if (fetchReq) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state <= RESPOND;
          end else begin
            refillCnt <= '0;
            state     <= REFILL_REQ;
          end
        end
        REFILL_REQ: begin
          // Hold req until the arbiter grants and memory acks
          if (busAck) begin
            if (lastWord) begin
              validArr[reqIndex] <= 1'b1;
            end
            state <= REFILL_WAIT;
          end
        end
        REFILL_WAIT: begin
          if (!busAck) begin
            if (lastWord) begin
              // Line complete so look up again to respond
              state <= LOOKUP;
            end else begin
              refillCnt <= refillCnt + 1'b1;
              state     <= REFILL_REQ;
            end
          end
        end
        RESPOND: begin
          if (!fetchReq) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Line fill and read-out
  always_ff @(posedge clk) begin
    if (state == REFILL_REQ && busAck) begin
      dataArr[reqIndex][refillCnt] <= busRData;
      if (lastWord) begin
        tagArr[reqIndex] <= reqTag;
      end
    end
    if (state == LOOKUP && hit) begin
      fetchData <= dataArr[reqIndex][reqOffset];
    end
  end

endmodule

//--- common/memSysPkg.sv
package memSysPkg;

  // Cache controller states shared by both caches
  // Store states only reached in the data cache
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    STORE_REQ,
    STORE_WAIT,
    RESPOND
  } cacheState;

  // Bus operation for data port, arbiter and memory
  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } busOp;

endpackage

//--- common/memSys_consts.svh
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// Main memory depth in 32-bit words
`define MEM_WORDS     1024

// Direct-mapped cache geometry
`define LINE_WORDS    4
`define NUM_LINES     16

// Byte address split into tag, index, word offset and byte offset
`define OFFSET_BITS   2
`define INDEX_BITS    4
`define TAG_BITS      24

// Rising edges from memReq seen high to memAck
`define MEM_LATENCY   3

// Word i of memory starts as i ^ INIT_PATTERN
`define INIT_PATTERN  32'h5A00_0000

`endif
